// File: hw/noc_input_port_config.svh
`ifndef NOC_INPUT_PORT_CONFIG_SVH
`define NOC_INPUT_PORT_CONFIG_SVH

// virtual channels per input port
`define NIP_V 4

// flits per vc buffer, also the upstream credit count
`define NIP_B 4

`define NIP_FPAY 32 // flit payload bits

`define NIP_XW 4 // mesh coordinate width

`define NIP_CLASSES 4 // message classes

// one V-bit output vc mask per class, class 0 in the low nibble
// class c may use vc c and above
`define NIP_CLASS_SETTING 16'h8CEF

`endif

// File: hw/noc_input_port_pkg.sv
`default_nettype none

`include "noc_input_port_config.svh"

package noc_input_port_pkg;

    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_t;

    typedef logic [`NIP_V-1:0]  vc_mask_t; // one-hot vc or a set of vcs
    typedef logic [`NIP_XW-1:0] coord_t;
    typedef logic [1:0]         class_t;

    localparam int HDR_SPARE_W = `NIP_FPAY - 4 * `NIP_XW - 5;

    // header view of the payload word
    typedef struct packed {
        coord_t                 dest_x;
        coord_t                 dest_y;
        coord_t                 src_x;
        coord_t                 src_y;
        class_t                 class_id;
        port_t                  lk_port;    // port to take at the receiving router
        logic [HDR_SPARE_W-1:0] spare;
    } hdr_payload_t;

    typedef union packed {
        hdr_payload_t          hdr;
        logic [`NIP_FPAY-1:0]  data;   // body flit word
    } payload_u;

    typedef struct packed {
        logic     hdr_flg;
        logic     tail_flg;
        vc_mask_t vc;
        payload_u payload;
    } flit_t;

endpackage

`default_nettype wire

// File: hw/lookahead_router.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module lookahead_router (
    input  wire                          clk,
    input  wire                          reset,
    input  wire noc_input_port_pkg::flit_t    flit_i,
    input  wire                          flit_we_i,
    input  wire noc_input_port_pkg::coord_t   cur_x_i,
    input  wire noc_input_port_pkg::coord_t   cur_y_i,
    output noc_input_port_pkg::vc_mask_t      lk_valid_o,
    output noc_input_port_pkg::port_t         cur_port_o,
    output noc_input_port_pkg::port_t         next_port_o,
    output noc_input_port_pkg::class_t        class_o
);

    import noc_input_port_pkg::*;

    hdr_payload_t hdr;
    coord_t       nb_x;     // router the flit goes to next
    coord_t       nb_y;
    port_t        xy_port;
    logic         hdr_wr;

    assign hdr    = flit_i.payload.hdr;
    assign hdr_wr = flit_we_i && flit_i.hdr_flg;

    always_comb begin
        nb_x = cur_x_i;
        nb_y = cur_y_i;
        case (hdr.lk_port)
            EAST:    nb_x = cur_x_i + coord_t'(1);
            WEST:    nb_x = cur_x_i - coord_t'(1);
            NORTH:   nb_y = cur_y_i + coord_t'(1);
            SOUTH:   nb_y = cur_y_i - coord_t'(1);
            default: ;  // local, same router
        endcase
    end

    // dimension order, x first
    always_comb begin
        if (hdr.dest_x > nb_x) begin
            xy_port = EAST;
        end else if (hdr.dest_x < nb_x) begin
            xy_port = WEST;
        end else if (hdr.dest_y > nb_y) begin
            xy_port = NORTH;
        end else if (hdr.dest_y < nb_y) begin
            xy_port = SOUTH;
        end else begin
            xy_port = LOCAL;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lk_valid_o <= '0;
        end else begin
            lk_valid_o <= hdr_wr ? flit_i.vc : '0;  // one pulse per header
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_wr) begin
            cur_port_o  <= hdr.lk_port;
            next_port_o <= xy_port;
            class_o     <= hdr.class_id;
        end
    end

endmodule

`default_nettype wire

// File: hw/flit_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module flit_buffer (
    input  wire                          clk,
    input  wire                          reset,
    input  wire noc_input_port_pkg::flit_t    flit_i,
    input  wire                          flit_we_i,
    input  wire noc_input_port_pkg::vc_mask_t rd_vc_i,
    output noc_input_port_pkg::flit_t         head_flit_o,
    output noc_input_port_pkg::vc_mask_t      not_empty_o,
    output noc_input_port_pkg::vc_mask_t      head_tail_o
);

    import noc_input_port_pkg::*;

    localparam int V  = `NIP_V;
    localparam int B  = `NIP_B;
    localparam int PW = (B > 1) ? $clog2(B) : 1;
    localparam int CW = $clog2(B + 1);

    vc_mask_t wr_vc;
    vc_mask_t rd_en;
    flit_t    head [V];   // head entry of each queue

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        ptr_inc = (p == PW'(B - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_vc = flit_we_i ? flit_i.vc : '0;
    assign rd_en = rd_vc_i & not_empty_o;

    for (genvar v = 0; v < V; v++) begin : g_vc
        flit_t         mem [B];
        logic [PW-1:0] wr_ptr;
        logic [PW-1:0] rd_ptr;
        logic [CW-1:0] count;

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (wr_vc[v]) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (rd_en[v]) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                if (wr_vc[v] && !rd_en[v]) begin
                    count <= count + 1'b1;
                end else if (!wr_vc[v] && rd_en[v]) begin
                    count <= count - 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (wr_vc[v]) begin
                mem[wr_ptr] <= flit_i;
            end
        end

        assign head[v]        = mem[rd_ptr];
        assign not_empty_o[v] = (count != '0);
        assign head_tail_o[v] = head[v].tail_flg;
    end

    // head of the vc being read
    always_comb begin
        head_flit_o = '0;
        for (int v = 0; v < V; v++) begin
            if (rd_vc_i[v]) begin
                head_flit_o = head[v];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/route_info_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module route_info_store (
    input  wire                          clk,
    input  wire                          reset,
    input  wire noc_input_port_pkg::vc_mask_t lk_valid_i,
    input  wire noc_input_port_pkg::port_t    cur_port_i,
    input  wire noc_input_port_pkg::port_t    next_port_i,
    input  wire noc_input_port_pkg::class_t   class_i,
    output noc_input_port_pkg::port_t         dest_port_o     [`NIP_V],
    output noc_input_port_pkg::port_t         next_port_o     [`NIP_V],
    output noc_input_port_pkg::vc_mask_t      candidate_ovc_o [`NIP_V]
);

    import noc_input_port_pkg::*;

    localparam int V = `NIP_V;
    localparam logic [`NIP_CLASSES*V-1:0] CLASS_SETTING = `NIP_CLASS_SETTING;

    class_t class_q [V];

    // one route per vc, loaded by the lookahead pulse of its header
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int v = 0; v < V; v++) begin
                dest_port_o[v] <= LOCAL;
                next_port_o[v] <= LOCAL;
                class_q[v]     <= '0;
            end
        end else begin
            for (int v = 0; v < V; v++) begin
                if (lk_valid_i[v]) begin
                    dest_port_o[v] <= cur_port_i;
                    next_port_o[v] <= next_port_i;
                    class_q[v]     <= class_i;
                end
            end
        end
    end

    // class to allowed output vcs
    always_comb begin
        for (int v = 0; v < V; v++) begin
            candidate_ovc_o[v] = CLASS_SETTING[class_q[v]*V +: V];
        end
    end

endmodule

`default_nettype wire

// File: hw/ivc_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module ivc_control (
    input  wire                          clk,
    input  wire                          reset,
    input  wire noc_input_port_pkg::vc_mask_t lk_valid_i,
    input  wire noc_input_port_pkg::vc_mask_t not_empty_i,
    input  wire noc_input_port_pkg::vc_mask_t head_tail_i,
    input  wire noc_input_port_pkg::vc_mask_t grant_ivc_i,
    output noc_input_port_pkg::vc_mask_t      ivc_request_o,
    output noc_input_port_pkg::vc_mask_t      rd_vc_o,
    output noc_input_port_pkg::vc_mask_t      credit_o,
    output noc_input_port_pkg::vc_mask_t      flit_is_tail_o
);

    import noc_input_port_pkg::*;

    vc_mask_t route_ready;  // route of the current packet is stored
    vc_mask_t rd_vc;
    vc_mask_t tail_done;

    // a vc competes only with a known route and a flit waiting
    assign ivc_request_o = route_ready & not_empty_i;

    assign rd_vc   = grant_ivc_i & ivc_request_o; // ignore grants on idle vcs
    assign rd_vc_o = rd_vc;

    assign tail_done      = rd_vc & head_tail_i;
    assign flit_is_tail_o = head_tail_i & not_empty_i; // stale head flags hidden

    // Atomic reallocation: a vc carries one packet at a time, so the tail
    // grant ends its route. A new header's lookahead may land on the same
    // edge as the old tail leaves, hence set has priority over clear.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            route_ready <= '0;
        end else begin
            route_ready <= (route_ready & ~tail_done) | lk_valid_i;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_o <= '0;
        end else begin
            credit_o <= rd_vc;  // one credit per flit leaving
        end
    end

endmodule

`default_nettype wire

// File: hw/header_updater.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module header_updater (
    input  wire                          clk,
    input  wire                          reset,
    input  wire noc_input_port_pkg::flit_t    head_flit_i,
    input  wire noc_input_port_pkg::vc_mask_t grant_ivc_i,
    input  wire noc_input_port_pkg::vc_mask_t grant_ovc_i,
    input  wire noc_input_port_pkg::port_t    next_port_i [`NIP_V],
    output noc_input_port_pkg::flit_t         flit_o,
    output logic                         flit_valid_o
);

    import noc_input_port_pkg::*;

    port_t lk_sel;  // lookahead of the granted vc

    always_comb begin
        lk_sel = LOCAL;
        for (int v = 0; v < `NIP_V; v++) begin
            if (grant_ivc_i[v]) begin
                lk_sel = next_port_i[v];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_valid_o <= 1'b0;
        end else begin
            flit_valid_o <= |grant_ivc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (|grant_ivc_i) begin
            flit_o    <= head_flit_i;
            flit_o.vc <= grant_ovc_i;  // every flit takes the output vc
            if (head_flit_i.hdr_flg) begin
                flit_o.payload.hdr.lk_port <= lk_sel;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/noc_input_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module noc_input_port (
    input  wire                          clk,
    input  wire                          reset,
    input  wire noc_input_port_pkg::coord_t   cur_x_i,
    input  wire noc_input_port_pkg::coord_t   cur_y_i,
    input  wire noc_input_port_pkg::flit_t    flit_i,
    input  wire                          flit_we_i,
    output wire noc_input_port_pkg::vc_mask_t credit_o,
    output wire noc_input_port_pkg::vc_mask_t ivc_request_o,
    output wire noc_input_port_pkg::port_t    dest_port_o     [`NIP_V],
    output wire noc_input_port_pkg::vc_mask_t candidate_ovc_o [`NIP_V],
    output wire noc_input_port_pkg::vc_mask_t flit_is_tail_o,
    input  wire noc_input_port_pkg::vc_mask_t grant_ivc_i,
    input  wire noc_input_port_pkg::vc_mask_t grant_ovc_i,
    output wire noc_input_port_pkg::flit_t    flit_o,
    output wire                          flit_valid_o
);

    wire noc_input_port_pkg::vc_mask_t lk_valid;
    wire noc_input_port_pkg::port_t    lk_cur_port;
    wire noc_input_port_pkg::port_t    lk_next_port;
    wire noc_input_port_pkg::class_t   lk_class;
    wire noc_input_port_pkg::port_t    next_port [`NIP_V];  // per-vc lookahead
    wire noc_input_port_pkg::vc_mask_t rd_vc;               // qualified grant
    wire noc_input_port_pkg::vc_mask_t not_empty;
    wire noc_input_port_pkg::vc_mask_t head_tail;
    wire noc_input_port_pkg::flit_t    head_flit;

    lookahead_router u_lookahead_router (
        .clk         (clk),
        .reset       (reset),
        .flit_i      (flit_i),
        .flit_we_i   (flit_we_i),
        .cur_x_i     (cur_x_i),
        .cur_y_i     (cur_y_i),
        .lk_valid_o  (lk_valid),
        .cur_port_o  (lk_cur_port),
        .next_port_o (lk_next_port),
        .class_o     (lk_class)
    );

    flit_buffer u_flit_buffer (
        .clk         (clk),
        .reset       (reset),
        .flit_i      (flit_i),
        .flit_we_i   (flit_we_i),
        .rd_vc_i     (rd_vc),
        .head_flit_o (head_flit),
        .not_empty_o (not_empty),
        .head_tail_o (head_tail)
    );

    route_info_store u_route_info_store (
        .clk             (clk),
        .reset           (reset),
        .lk_valid_i      (lk_valid),
        .cur_port_i      (lk_cur_port),
        .next_port_i     (lk_next_port),
        .class_i         (lk_class),
        .dest_port_o     (dest_port_o),
        .next_port_o     (next_port),
        .candidate_ovc_o (candidate_ovc_o)
    );

    ivc_control u_ivc_control (
        .clk            (clk),
        .reset          (reset),
        .lk_valid_i     (lk_valid),
        .not_empty_i    (not_empty),
        .head_tail_i    (head_tail),
        .grant_ivc_i    (grant_ivc_i),
        .ivc_request_o  (ivc_request_o),
        .rd_vc_o        (rd_vc),
        .credit_o       (credit_o),
        .flit_is_tail_o (flit_is_tail_o)
    );

    header_updater u_header_updater (
        .clk          (clk),
        .reset        (reset),
        .head_flit_i  (head_flit),
        .grant_ivc_i  (rd_vc),
        .grant_ovc_i  (grant_ovc_i),
        .next_port_i  (next_port),
        .flit_o       (flit_o),
        .flit_valid_o (flit_valid_o)
    );

endmodule

`default_nettype wire

// File: verif/noc_input_port_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module noc_input_port_sva (
    input wire                               clk,
    input wire                               reset,
    input wire noc_input_port_pkg::vc_mask_t lk_valid_i,
    input wire noc_input_port_pkg::vc_mask_t head_tail_i,
    input wire noc_input_port_pkg::vc_mask_t grant_ivc_i,
    input wire noc_input_port_pkg::vc_mask_t ivc_request_o,
    input wire noc_input_port_pkg::vc_mask_t credit_o
);

    import noc_input_port_pkg::*;

    grant_on_request: assert property (
        @(posedge clk) disable iff (reset) (grant_ivc_i & ~ivc_request_o) == '0
    ) else $error("grant on a vc without a request");

    credit_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(credit_o)
    ) else $error("more than one credit returned in a cycle");

    for (genvar v = 0; v < `NIP_V; v++) begin : g_tail
        // a route landing on the tail edge reopens the vc at once
        tail_ends_request: assert property (
            @(posedge clk) disable iff (reset)
            grant_ivc_i[v] && head_tail_i[v] && !lk_valid_i[v] |=> !ivc_request_o[v]
        ) else $error("request still high after tail grant on vc %0d", v);
    end

endmodule

bind ivc_control noc_input_port_sva u_ivc_control_sva (
    .clk           (clk),
    .reset         (reset),
    .lk_valid_i    (lk_valid_i),
    .head_tail_i   (head_tail_i),
    .grant_ivc_i   (grant_ivc_i),
    .ivc_request_o (ivc_request_o),
    .credit_o      (credit_o)
);

`default_nettype wire

// File: verif/noc_input_port_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "noc_input_port_config.svh"

module noc_input_port_tb;

    import noc_input_port_pkg::*;

    localparam int V           = `NIP_V;
    localparam int B           = `NIP_B;
    localparam int CLK_PERIOD  = 8;
    localparam int STIM_CYCLES = 250;  // upper estimate of all tests together
    localparam int WDOG_CYCLES = STIM_CYCLES * 4 + 100;
    localparam logic [31:0] SEED = 32'h005a3c67;

    logic     clk;
    logic     reset;
    coord_t   cur_x;
    coord_t   cur_y;
    flit_t    flit_in;
    logic     flit_we;
    vc_mask_t credit;
    vc_mask_t ivc_request;
    port_t    dest_port [V];
    vc_mask_t candidate_ovc [V];
    vc_mask_t flit_is_tail;
    vc_mask_t grant_ivc;
    vc_mask_t grant_ovc;
    flit_t    flit_out;
    logic     flit_valid;

    flit_t  exp_q [V][$];  // expected output flits per input vc
    int     sent [V];      // flits sent upstream, per vc
    int     returned [V];  // credits seen back, per vc
    port_t  exp_dest [V];
    class_t exp_class [V];
    int     errors;
    int     mon_errors;
    int     checks;
    int     test_errors;
    string  test_name;

    noc_input_port u_noc_input_port (
        .clk             (clk),
        .reset           (reset),
        .cur_x_i         (cur_x),
        .cur_y_i         (cur_y),
        .flit_i          (flit_in),
        .flit_we_i       (flit_we),
        .credit_o        (credit),
        .ivc_request_o   (ivc_request),
        .dest_port_o     (dest_port),
        .candidate_ovc_o (candidate_ovc),
        .flit_is_tail_o  (flit_is_tail),
        .grant_ivc_i     (grant_ivc),
        .grant_ovc_i     (grant_ovc),
        .flit_o          (flit_out),
        .flit_valid_o    (flit_valid)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // neighbor in the lookahead direction, then x before y
    function automatic port_t xy_next(input coord_t cx, input coord_t cy, input hdr_payload_t h);
        coord_t nx;
        coord_t ny;
        nx = cx;
        ny = cy;
        case (h.lk_port)
            EAST:    nx = cx + coord_t'(1);
            WEST:    nx = cx - coord_t'(1);
            NORTH:   ny = cy + coord_t'(1);
            SOUTH:   ny = cy - coord_t'(1);
            default: ;
        endcase
        if (h.dest_x != nx) begin
            return (h.dest_x > nx) ? EAST : WEST;
        end else if (h.dest_y != ny) begin
            return (h.dest_y > ny) ? NORTH : SOUTH;
        end
        return LOCAL;
    endfunction

    // class c may use output vcs c and up
    function automatic vc_mask_t class_mask(input class_t c);
        vc_mask_t m;
        m = '0;
        for (int i = 0; i < V; i++) begin
            m[i] = (i >= int'(c));
        end
        return m;
    endfunction

    function automatic vc_mask_t pick_ovc(input class_t c);
        return vc_mask_t'(1 << $urandom_range(V - 1, int'(c)));
    endfunction

    function automatic payload_u make_hdr(input coord_t dx, input coord_t dy, input class_t c,
                                          input port_t lk);
        payload_u p;
        p.data         = $urandom;  // src and spare stay random
        p.hdr.dest_x   = dx;
        p.hdr.dest_y   = dy;
        p.hdr.class_id = c;
        p.hdr.lk_port  = lk;
        return p;
    endfunction

    function automatic payload_u body_data();
        payload_u p;
        p.data = $urandom;
        return p;
    endfunction

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic end_test();
        int now_err;
        now_err = errors + mon_errors;
        $display("test %-14s %s", test_name, (now_err == test_errors) ? "passed" : "FAILED");
        test_errors = now_err;
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_flit(input int v, input logic hdr, input logic tail, input payload_u pay);
        flit_t f;
        flit_t e;
        while (B - sent[v] + returned[v] <= 0) begin
            @(negedge clk);  // no credit left for this vc
        end
        f.hdr_flg  = hdr;
        f.tail_flg = tail;
        f.vc       = vc_mask_t'(1 << v);
        f.payload  = pay;
        e          = f;
        if (hdr) begin
            e.payload.hdr.lk_port = xy_next(cur_x, cur_y, pay.hdr);
            exp_dest[v]           = pay.hdr.lk_port;
            exp_class[v]          = pay.hdr.class_id;
        end
        exp_q[v].push_back(e);
        sent[v]++;
        flit_in = f;
        flit_we = 1'b1;
        @(negedge clk);
        flit_we = 1'b0;
    endtask

    task automatic grant_vc(input int v, input vc_mask_t ovc);
        flit_t e;
        while (!ivc_request[v]) begin
            @(negedge clk);
        end
        e         = exp_q[v].pop_front();
        e.vc      = ovc;
        grant_ivc = vc_mask_t'(1 << v);
        grant_ovc = ovc;
        @(negedge clk);
        grant_ivc = '0;
        grant_ovc = '0;
        check_eq("flit_valid", 1, flit_valid);
        check_eq("flit", e, flit_out);
        check_eq("credit", vc_mask_t'(1 << v), credit);
    endtask

    // credit counting and credit/valid alignment
    always @(posedge clk) begin
        if (reset) begin
            for (int v = 0; v < V; v++) begin
                returned[v] = 0;
            end
        end else begin
            for (int v = 0; v < V; v++) begin
                if (credit[v]) begin
                    returned[v] = returned[v] + 1;
                end
            end
            assert (flit_valid == (credit != '0)) else begin
                mon_errors++;
                $display("credit return and flit_valid_o out of step in test %s", test_name);
            end
        end
    end

    task automatic run_reset_test();
        test_name = "reset";
        check_eq("ivc_request", 0, ivc_request);
        check_eq("credit", 0, credit);
        check_eq("flit_valid", 0, flit_valid);
        end_test();
    endtask

    task automatic run_route_class_test();
        vc_mask_t all_vc;
        test_name = "route_class";
        all_vc    = '1;
        for (int v = 0; v < V; v++) begin
            send_flit(v, 1'b1, 1'b1, make_hdr(coord_t'($urandom), coord_t'($urandom),
                      class_t'($urandom_range(3, 0)), port_t'($urandom_range(4, 0))));
        end
        while (ivc_request != all_vc) begin
            @(negedge clk);
        end
        for (int v = 0; v < V; v++) begin
            check_eq("dest_port", exp_dest[v], dest_port[v]);
            check_eq("candidate_ovc", class_mask(exp_class[v]), candidate_ovc[v]);
        end
        for (int v = 0; v < V; v++) begin
            grant_vc(v, pick_ovc(exp_class[v]));
        end
        end_test();
    endtask

    task automatic run_header_rewrite_test();
        int     v;
        class_t c;
        coord_t dx;
        test_name = "hdr_rewrite";
        for (int i = 0; i < 8; i++) begin
            cur_x = coord_t'($urandom);
            cur_y = coord_t'($urandom);
            v     = int'($urandom_range(V - 1, 0));
            c     = class_t'($urandom_range(3, 0));
            dx    = (i % 2 == 0) ? cur_x : coord_t'($urandom);  // same column now and then
            send_flit(v, 1'b1, 1'b1,
                      make_hdr(dx, coord_t'($urandom), c, port_t'($urandom_range(4, 0))));
            grant_vc(v, pick_ovc(c));
        end
        end_test();
    endtask

    task automatic run_order_credit_test();
        payload_u pay;
        test_name = "order_credits";
        for (int i = 0; i < B; i++) begin
            for (int v = 0; v < V; v += V - 1) begin  // first and last vc interleaved
                pay = (i == 0) ? make_hdr(coord_t'($urandom), coord_t'($urandom), class_t'(0),
                                          EAST) : body_data();
                send_flit(v, i == 0, i == B - 1, pay);
            end
        end
        for (int i = 0; i < B; i++) begin
            grant_vc(0, pick_ovc(exp_class[0]));
            grant_vc(V - 1, pick_ovc(exp_class[V - 1]));
        end
        @(negedge clk);
        for (int v = 0; v < V; v++) begin
            check_eq("credits_back", sent[v], returned[v]);
        end
        end_test();
    endtask

    task automatic run_packet_end_test();
        vc_mask_t all_vc;
        vc_mask_t others;
        vc_mask_t tail_ovc;
        payload_u next_hdr;
        test_name = "packet_end";
        all_vc    = '1;
        others    = ~vc_mask_t'(2);
        for (int v = 0; v < V; v++) begin
            send_flit(v, 1'b1, 1'b0, make_hdr(coord_t'($urandom), coord_t'($urandom),
                      class_t'($urandom_range(3, 0)), NORTH));
        end
        send_flit(1, 1'b0, 1'b0, body_data());
        send_flit(1, 1'b0, 1'b1, body_data());
        while (ivc_request != all_vc) begin
            @(negedge clk);
        end
        grant_vc(1, pick_ovc(exp_class[1]));
        grant_vc(1, pick_ovc(exp_class[1]));
        check_eq("flit_is_tail", 1, flit_is_tail[1]);
        tail_ovc = pick_ovc(exp_class[1]);
        next_hdr = make_hdr(coord_t'($urandom), coord_t'($urandom), class_t'(1), WEST);
        fork
            grant_vc(1, tail_ovc);              // tail leaves
            send_flit(1, 1'b1, 1'b1, next_hdr); // next header written on the same edge
        join
        check_eq("ivc_request", others, ivc_request);  // route still in flight
        @(negedge clk);
        check_eq("ivc_request", all_vc, ivc_request);
        grant_vc(1, pick_ovc(exp_class[1]));
        for (int v = 0; v < V; v++) begin
            if (v != 1) begin
                send_flit(v, 1'b0, 1'b1, body_data());
                grant_vc(v, pick_ovc(exp_class[v]));
                grant_vc(v, pick_ovc(exp_class[v]));
            end
        end
        end_test();
    endtask

    task automatic run_backpressure_test();
        payload_u pay;
        test_name = "backpressure";
        for (int i = 0; i < B; i++) begin
            pay = (i == 0) ? make_hdr(coord_t'($urandom), coord_t'($urandom), class_t'(2),
                                      SOUTH) : body_data();
            send_flit(2, i == 0, i == B - 1, pay);
        end
        check_eq("credits_out", B, sent[2] - returned[2]);
        repeat (8) begin
            check_eq("flit_valid", 0, flit_valid);
            check_eq("credit", 0, credit);
            @(negedge clk);
        end
        for (int i = 0; i < B; i++) begin
            grant_vc(2, pick_ovc(exp_class[2]));
        end
        @(negedge clk);
        check_eq("credits_back", sent[2], returned[2]);
        end_test();
    endtask

    initial begin
        void'($urandom(SEED));
        reset     = 1'b1;
        cur_x     = '0;
        cur_y     = '0;
        flit_in   = '0;
        flit_we   = 1'b0;
        grant_ivc = '0;
        grant_ovc = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_reset_test();
        run_route_class_test();
        run_header_rewrite_test();
        run_order_credit_test();
        run_packet_end_test();
        run_backpressure_test();
        repeat (2) @(negedge clk);
        $display("tests: 6, checks: %0d, errors: %0d", checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not complete within %0d cycles", WDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: noc_input_port.f
+incdir+hw
hw/noc_input_port_pkg.sv
hw/lookahead_router.sv
hw/flit_buffer.sv
hw/route_info_store.sv
hw/ivc_control.sv
hw/header_updater.sv
hw/noc_input_port.sv
verif/noc_input_port_sva.sv
verif/noc_input_port_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= noc_input_port_tb
RTL_TOP   ?= noc_input_port
FILELIST  ?= noc_input_port.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qx "Finished with errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
